//--- compile.f
src/fft_pkg.sv
src/sample_ram.sv
src/mem_arbiter.sv
src/fft_apb_port.sv
src/stage_addr_gen.sv
src/butterfly.sv
src/fft_engine.sv
src/fft16.sv
test/tb_fft16.sv

//--- Makefile
TOP = tb_fft16

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "Simulation reported failure, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- test/tb_fft16.sv
`timescale 1ns/1ps

module tb_fft16 import fft_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int value_errors;
    int other_errors;
    int runs_done;
    int samp_re [fft_n];
    int samp_im [fft_n];
    int exp_re [fft_n];
    int exp_im [fft_n];
    int tw_c [8];
    int tw_s [8];

    fft16 fft16_inst (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // Bus protocol monitors
    // **************************************************
    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable))
        else begin
            other_errors++;
            $display("pready was high outside an APB access phase at %0t", $time);
        end

    a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else begin
            other_errors++;
            $display("pslverr was high without pready at %0t", $time);
        end

    a_no_double_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(fft16_inst.e_gnt && fft16_inst.a_gnt))
        else begin
            other_errors++;
            $display("Both RAM requesters were granted in one cycle at %0t", $time);
        end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    function automatic int round_q14(input real x);
        real scaled;
        scaled = x * (1 << tw_frac);
        if (scaled >= 0.0) begin
            return $rtoi(scaled + 0.5);
        end
        return -$rtoi(0.5 - scaled);
    endfunction

    task automatic build_twiddles();
        real ang;
        for (int k = 0; k < 8; k++) begin
            ang = 2.0 * 3.14159265358979 * k / fft_n;
            tw_c[k] = round_q14($cos(ang));
            tw_s[k] = round_q14(-$sin(ang));
        end
    endtask

    function automatic int bit_reverse(input int n);
        int r;
        r = 0;
        for (int b = 0; b < addr_w; b++) begin
            r = (r << 1) | ((n >> b) & 1);
        end
        return r;
    endfunction

    // In-place DIT, floor after every product and a halving per stage
    task automatic compute_reference();
        int span;
        int top;
        int bot;
        int w;
        int t_re;
        int t_im;
        int a_re;
        int a_im;
        for (int n = 0; n < fft_n; n++) begin
            exp_re[bit_reverse(n)] = samp_re[n];
            exp_im[bit_reverse(n)] = samp_im[n];
        end
        for (int s = 0; s < log2_n; s++) begin
            span = 1 << s;
            for (int base = 0; base < fft_n; base += 2 * span) begin
                for (int k = 0; k < span; k++) begin
                    top  = base + k;
                    bot  = top + span;
                    w    = k << (log2_n - 1 - s);
                    t_re = (exp_re[bot] * tw_c[w]) >>> tw_frac;
                    t_re = t_re - ((exp_im[bot] * tw_s[w]) >>> tw_frac);
                    t_im = (exp_re[bot] * tw_s[w]) >>> tw_frac;
                    t_im = t_im + ((exp_im[bot] * tw_c[w]) >>> tw_frac);
                    a_re = exp_re[top];
                    a_im = exp_im[top];
                    exp_re[top] = (a_re + t_re) >>> 1;
                    exp_im[top] = (a_im + t_im) >>> 1;
                    exp_re[bot] = (a_re - t_re) >>> 1;
                    exp_im[bot] = (a_im - t_im) >>> 1;
                end
            end
        end
    endtask

    // **************************************************
    // APB driver
    // **************************************************
    task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] wd,
                              output logic [31:0] rd, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= wd;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!pready && waited < 40);
        if (!pready) begin
            other_errors++;
            $display("APB access to address %h got no pready within 40 cycles", a);
        end
        rd  = prdata;
        err = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
        logic [31:0] unused_rd;
        apb_access(1'b1, a, d, unused_rd, err);
    endtask

    task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
        apb_access(1'b0, a, 32'd0, d, err);
    endtask

    task automatic load_samples();
        logic err;
        for (int n = 0; n < fft_n; n++) begin
            apb_write(win_base + 8'(4 * n), {samp_re[n][15:0], samp_im[n][15:0]}, err);
            check_value("pslverr", 32'd0, {31'd0, err});
        end
    endtask

    task automatic check_bins();
        logic [31:0] rd;
        logic        err;
        logic [31:0] expected;
        for (int k = 0; k < fft_n; k++) begin
            apb_read(win_base + 8'(4 * k), rd, err);
            expected = {exp_re[k][15:0], exp_im[k][15:0]};
            check_value($sformatf("bin[%0d]", k), expected, rd);
            check_value("pslverr", 32'd0, {31'd0, err});
        end
    endtask

    task automatic run_fft(input bit poke_window);
        logic [31:0] st;
        logic        err;
        int          polls;
        // Done from the previous run is still set
        if (runs_done > 0) begin
            apb_read(reg_status, st, err);
            check_value("reg_status", 32'h2, st);
        end
        apb_write(reg_ctrl, 32'h1, err);
        check_value("pslverr", 32'd0, {31'd0, err});
        apb_read(reg_status, st, err);
        check_value("reg_status", 32'h1, st);
        if (poke_window) begin
            apb_write(win_base + 8'h14, 32'hdead_beef, err);
            check_value("pslverr", 32'd1, {31'd0, err});
            apb_read(win_base + 8'h08, st, err);
            check_value("pslverr", 32'd1, {31'd0, err});
        end
        polls = 0;
        do begin
            apb_read(reg_status, st, err);
            polls++;
            if (st != 32'h2) begin
                check_value("reg_status", 32'h1, st);
            end
        end while (st != 32'h2 && polls < 300);
        if (st != 32'h2) begin
            other_errors++;
            $display("Engine did not report done after %0d status reads", polls);
        end
        repeat (8) @(posedge clk);
        apb_read(reg_status, st, err);
        check_value("reg_status", 32'h2, st);
        runs_done++;
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        value_errors = 0;
        other_errors = 0;
        runs_done    = 0;
        rst_n   = 1'b0;
        paddr   = 8'd0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'd0;
        void'($urandom(32'h5fe2_5b83));
        build_twiddles();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        repeat (4) begin
            @(posedge clk);
            check_value("pready", 32'd0, {31'd0, pready});
            check_value("pslverr", 32'd0, {31'd0, pslverr});
        end
        apb_read(reg_status, rd, err);
        check_value("reg_status", 32'd0, rd);
        check_value("pslverr", 32'd0, {31'd0, err});

        // Impulse gives a flat real spectrum of 16384 / 16
        for (int n = 0; n < fft_n; n++) begin
            samp_re[n] = (n == 0) ? 16384 : 0;
            samp_im[n] = 0;
            exp_re[n]  = 16384 / fft_n;
            exp_im[n]  = 0;
        end
        load_samples();
        run_fft(1'b0);
        check_bins();

        for (int set = 0; set < 3; set++) begin
            for (int n = 0; n < fft_n; n++) begin
                samp_re[n] = int'($urandom_range(16382, 0)) - 8191;
                samp_im[n] = int'($urandom_range(16382, 0)) - 8191;
            end
            load_samples();
            compute_reference();
            run_fft(set == 1);
            check_bins();
        end

        $display("Checks finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src/fft16.sv
`timescale 1ns/1ps

module fft16 import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [word_w-1:0] pwdata,
    output logic [word_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic              start;
    logic              busy;
    logic              done;
    logic              e_req;
    logic              e_we;
    logic [addr_w-1:0] e_addr;
    logic [word_w-1:0] e_wdata;
    logic              e_gnt;
    logic              a_req;
    logic              a_we;
    logic [addr_w-1:0] a_addr;
    logic [word_w-1:0] a_wdata;
    logic              a_gnt;
    logic              ram_en;
    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [word_w-1:0] ram_wdata;
    logic [word_w-1:0] ram_rdata;

    fft_apb_port u_apb (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .busy(busy), .done(done), .start(start),
        .req(a_req), .gnt(a_gnt), .we(a_we), .addr(a_addr), .wdata(a_wdata),
        .rdata(ram_rdata)
    );

    fft_engine u_engine (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done),
        .req(e_req), .gnt(e_gnt), .we(e_we), .addr(e_addr), .wdata(e_wdata),
        .rdata(ram_rdata)
    );

    // Engine first, APB second
    mem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .e_req(e_req), .e_we(e_we), .e_addr(e_addr), .e_wdata(e_wdata), .e_gnt(e_gnt),
        .a_req(a_req), .a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata), .a_gnt(a_gnt),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

    sample_ram u_ram (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

//--- src/fft_engine.sv
`timescale 1ns/1ps

module fft_engine import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output logic              req,
    input  logic              gnt,
    output logic              we,
    output logic [addr_w-1:0] addr,
    output logic [word_w-1:0] wdata,
    input  logic [word_w-1:0] rdata
);

    eng_state_t        state;
    logic [1:0]        stage_q;
    logic              rd_pend_q;
    logic [word_w-1:0] top_q;
    logic              start_stage;
    logic              advance;
    logic              valid;
    logic [addr_w-1:0] addr_top;
    logic [addr_w-1:0] addr_bot;
    logic [2:0]        tw_idx;
    logic              last_bfly;
    logic              stage_done;
    logic [word_w-1:0] res_top;
    logic [word_w-1:0] res_bot;

    // Next stage is kicked off once the generator reports the previous one
    assign start_stage = (state == eng_idle && start) || (state == eng_rd_top && stage_done);
    assign advance     = (state == eng_wr_bot) && gnt;

    assign req   = valid && (state inside {eng_rd_top, eng_rd_bot, eng_wr_top, eng_wr_bot});
    assign we    = (state == eng_wr_top) || (state == eng_wr_bot);
    assign addr  = (state == eng_rd_top || state == eng_wr_top) ? addr_top : addr_bot;
    assign wdata = (state == eng_wr_top) ? res_top : res_bot;

    stage_addr_gen u_agen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_stage(start_stage),
        .stage      (stage_q),
        .advance    (advance),
        .valid      (valid),
        .addr_top   (addr_top),
        .addr_bot   (addr_bot),
        .tw_idx     (tw_idx),
        .last_bfly  (last_bfly),
        .stage_done (stage_done)
    );

    // Bottom operand is still held in the RAM output register during calc
    butterfly u_bfly (
        .clk    (clk),
        .rst_n  (rst_n),
        .top    (top_q),
        .bot    (rdata),
        .tw_idx (tw_idx),
        .calc   (state == eng_calc),
        .res_top(res_top),
        .res_bot(res_bot)
    );

    // **************************************************
    // Butterfly sequencer
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= eng_idle;
            stage_q   <= '0;
            rd_pend_q <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            rd_pend_q <= gnt && !we;
            case (state)
                eng_idle: if (start) begin
                    busy    <= 1'b1;
                    done    <= 1'b0;
                    stage_q <= '0;
                    state   <= eng_rd_top;
                end
                eng_rd_top: if (gnt) state <= eng_rd_bot;
                eng_rd_bot: if (gnt) state <= eng_calc;
                eng_calc:   state <= eng_wr_top;
                eng_wr_top: if (gnt) state <= eng_wr_bot;
                eng_wr_bot: if (gnt) begin
                    if (last_bfly && stage_q == 2'(log2_n - 1)) begin
                        state <= eng_done;
                    end else begin
                        if (last_bfly) stage_q <= stage_q + 1'b1;
                        state <= eng_rd_top;
                    end
                end
                eng_done: if (stage_done) begin
                    busy    <= 1'b0;
                    done    <= 1'b1;
                    stage_q <= '0;
                    state   <= eng_idle;
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // top leg arrives the cycle after its read grant
    always_ff @(posedge clk) begin
        if (state == eng_rd_bot && rd_pend_q) top_q <= rdata;
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req && !gnt |=> req && $stable(addr));

endmodule

//--- src/butterfly.sv
`timescale 1ns/1ps

module butterfly import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [word_w-1:0] top,
    input  logic [word_w-1:0] bot,
    input  logic [2:0]        tw_idx,
    input  logic              calc,
    output logic [word_w-1:0] res_top,
    output logic [word_w-1:0] res_bot
);

    logic signed [data_w-1:0]   top_re;
    logic signed [data_w-1:0]   top_im;
    logic signed [data_w-1:0]   bot_re;
    logic signed [data_w-1:0]   bot_im;
    logic signed [data_w-1:0]   wc;
    logic signed [data_w-1:0]   ws;
    logic signed [2*data_w-1:0] p_rc;
    logic signed [2*data_w-1:0] p_is;
    logic signed [2*data_w-1:0] p_rs;
    logic signed [2*data_w-1:0] p_ic;
    logic signed [17:0]         t_re;
    logic signed [17:0]         t_im;
    logic signed [17:0]         sum_re;
    logic signed [17:0]         sum_im;
    logic signed [17:0]         dif_re;
    logic signed [17:0]         dif_im;

    assign top_re = top[word_w-1:data_w];
    assign top_im = top[data_w-1:0];
    assign bot_re = bot[word_w-1:data_w];
    assign bot_im = bot[data_w-1:0];
    assign wc     = tw_cos[tw_idx];
    assign ws     = tw_sin_neg[tw_idx];

    // t = bot * W, each product floored back to integer scale
    assign p_rc = bot_re * wc;
    assign p_is = bot_im * ws;
    assign p_rs = bot_re * ws;
    assign p_ic = bot_im * wc;
    assign t_re = 18'(p_rc >>> tw_frac) - 18'(p_is >>> tw_frac);
    assign t_im = 18'(p_rs >>> tw_frac) + 18'(p_ic >>> tw_frac);

    assign sum_re = top_re + t_re;
    assign sum_im = top_im + t_im;
    assign dif_re = top_re - t_re;
    assign dif_im = top_im - t_im;

    // Halve every stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_top <= '0;
            res_bot <= '0;
        end else if (calc) begin
            res_top <= {data_w'(sum_re >>> 1), data_w'(sum_im >>> 1)};
            res_bot <= {data_w'(dif_re >>> 1), data_w'(dif_im >>> 1)};
        end
    end

endmodule

//--- src/stage_addr_gen.sv
`timescale 1ns/1ps

module stage_addr_gen import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_stage,
    input  logic [1:0]        stage,
    input  logic              advance,
    output logic              valid,
    output logic [addr_w-1:0] addr_top,
    output logic [addr_w-1:0] addr_bot,
    output logic [2:0]        tw_idx,
    output logic              last_bfly,
    output logic              stage_done
);

    agen_state_t       state;
    logic [1:0]        stage_q;
    logic [addr_w-1:0] i_q;
    logic [addr_w-2:0] k_q;
    logic [addr_w-1:0] span;

    assign span = addr_w'(1) << stage_q;

    // i is the even group base, k the index inside the group
    assign addr_top = (i_q << stage_q) + addr_w'(k_q);
    assign addr_bot = ((i_q + 1'b1) << stage_q) + addr_w'(k_q);
    assign tw_idx   = 3'(k_q << (log2_n - 1 - stage_q));

    assign valid      = (state == agen_run);
    assign stage_done = (state == agen_last);
    // Every stage ends on the pair whose lower leg is the last address
    assign last_bfly  = valid && (addr_bot == addr_w'(fft_n - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= agen_idle;
            stage_q <= '0;
            i_q     <= '0;
            k_q     <= '0;
        end else begin
            case (state)
                agen_idle, agen_last: begin
                    if (start_stage) begin
                        state   <= agen_run;
                        stage_q <= stage;
                        i_q     <= '0;
                        k_q     <= '0;
                    end else begin
                        state <= agen_idle;
                    end
                end
                agen_run: begin
                    if (advance && last_bfly) begin
                        state <= agen_last;
                    end else if (advance) begin
                        if (addr_w'(k_q) == span - 1'b1) begin
                            k_q <= '0;
                            i_q <= i_q + 2'd2;
                        end else begin
                            k_q <= k_q + 1'b1;
                        end
                    end
                end
                default: state <= agen_idle;
            endcase
        end
    end

    // Top leg sits in the lower half of its group, so the pair never wraps
    a_span: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> (addr_w'(addr_bot - addr_top) == span) && ((addr_top & span) == '0));

endmodule

//--- src/fft_apb_port.sv
`timescale 1ns/1ps

module fft_apb_port import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [word_w-1:0] pwdata,
    output logic [word_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              busy,
    input  logic              done,
    output logic              start,
    output logic              req,
    input  logic              gnt,
    output logic              we,
    output logic [addr_w-1:0] addr,
    output logic [word_w-1:0] wdata,
    input  logic [word_w-1:0] rdata
);

    apb_state_t        state;
    logic              setup_phase;
    logic              is_win;
    logic [addr_w-1:0] win_idx;
    logic [addr_w-1:0] win_rev;

    assign setup_phase = psel && !penable;
    assign is_win      = (paddr >= win_base) && (paddr < win_base + 4 * fft_n);
    assign win_idx     = paddr[addr_w+1:2];

    // Samples go in bit-reversed so the bins come out in natural order
    always_comb begin
        for (int b = 0; b < addr_w; b++) begin
            win_rev[b] = win_idx[addr_w-1-b];
        end
    end

    // **************************************************
    // Transfer sequencing
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= apb_setup;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            start   <= 1'b0;
            req     <= 1'b0;
        end else begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            start   <= 1'b0;
            case (state)
                apb_setup: begin
                    if (setup_phase && is_win && busy) begin
                        pready  <= 1'b1;
                        pslverr <= 1'b1;
                    end else if (setup_phase && is_win) begin
                        req   <= 1'b1;
                        state <= apb_wait_grant;
                    end else if (setup_phase) begin
                        pready <= 1'b1;
                        start  <= pwrite && (paddr == reg_ctrl) && pwdata[0];
                    end
                end
                apb_wait_grant: begin
                    if (gnt) begin
                        req <= 1'b0;
                        if (we) begin
                            pready <= 1'b1;
                            state  <= apb_setup;
                        end else begin
                            state <= apb_wait_data;
                        end
                    end
                end
                apb_wait_data: begin
                    pready <= 1'b1;
                    state  <= apb_setup;
                end
                default: state <= apb_setup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == apb_setup && setup_phase) begin
            we     <= pwrite;
            addr   <= pwrite ? win_rev : win_idx;
            wdata  <= pwdata;
            prdata <= (paddr == reg_status) ? {{(word_w-2){1'b0}}, done, busy} : '0;
        end else if (state == apb_wait_data) begin
            prdata <= rdata;
        end
    end

    a_enable_sel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import fft_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // engine side
    input  logic              e_req,
    input  logic              e_we,
    input  logic [addr_w-1:0] e_addr,
    input  logic [word_w-1:0] e_wdata,
    output logic              e_gnt,
    // APB side
    input  logic              a_req,
    input  logic              a_we,
    input  logic [addr_w-1:0] a_addr,
    input  logic [word_w-1:0] a_wdata,
    output logic              a_gnt,
    // RAM side
    output logic              ram_en,
    output logic              ram_we,
    output logic [addr_w-1:0] ram_addr,
    output logic [word_w-1:0] ram_wdata
);

    logic gnt_any;

    assign gnt_any = e_gnt || a_gnt;

    // No new grant while one is live
    // The requester still holds req in its grant cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_gnt <= 1'b0;
            a_gnt <= 1'b0;
        end else begin
            e_gnt <= e_req && !gnt_any;
            a_gnt <= a_req && !e_req && !gnt_any;
        end
    end

    // Winner drives the RAM during its grant cycle
    assign ram_en    = gnt_any;
    assign ram_we    = e_gnt ? e_we : (a_gnt && a_we);
    assign ram_addr  = e_gnt ? e_addr : a_addr;
    assign ram_wdata = e_gnt ? e_wdata : a_wdata;

    // At most one grant, and only to a requester that still holds its request
    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !(e_gnt && a_gnt) && (!e_gnt || e_req) && (!a_gnt || a_req));

endmodule

//--- src/sample_ram.sv
`timescale 1ns/1ps

module sample_ram import fft_pkg::*; (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [addr_w-1:0] addr,
    input  logic [word_w-1:0] wdata,
    output logic [word_w-1:0] rdata
);

    // Real part in the upper half, imaginary part in the lower half
    logic [word_w-1:0] mem [fft_n];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- src/fft_pkg.sv
package fft_pkg;

    // **************************************************
    // Sizes
    // **************************************************
    localparam int fft_n   = 16;
    localparam int log2_n  = 4;
    localparam int addr_w  = 4;
    localparam int data_w  = 16;
    localparam int word_w  = 32;
    localparam int tw_frac = 14;

    // Q1.14 twiddles for W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
    localparam logic signed [data_w-1:0] tw_cos [0:7] = '{
        16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270,
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137
    };
    localparam logic signed [data_w-1:0] tw_sin_neg [0:7] = '{
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
        -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
    };

    // APB byte addresses
    localparam logic [7:0] reg_ctrl   = 8'h00;
    localparam logic [7:0] reg_status = 8'h04;
    localparam logic [7:0] win_base   = 8'h40;

    typedef enum logic [2:0] {
        eng_idle, eng_rd_top, eng_rd_bot, eng_calc, eng_wr_top, eng_wr_bot, eng_done
    } eng_state_t;

    typedef enum logic [1:0] {agen_idle, agen_run, agen_last} agen_state_t;

    typedef enum logic [1:0] {apb_setup, apb_wait_grant, apb_wait_data} apb_state_t;

endpackage
